// File: verilog/pad_defs.svh
// ================================================
// Pad ring sizing macros.
// Pad count and the width of a pad index.
// ================================================

`ifndef PAD_DEFS_SVH
`define PAD_DEFS_SVH

// Number of pads in the ring, at least 2.
`define PAD_NUM 8

// Width of a pad index, the base-2 log of PAD_NUM rounded up.
`define PAD_IDX_W 3

`endif

// File: verilog/pad_pkg.sv
// ================================================
// Pad ring types.
// Pad modes and configuration opcodes.
// ================================================

package pad_pkg;

  // Operating mode of one pad.
  typedef enum logic [1:0] {
    PAD_OFF        = 2'd0,
    PAD_PUSH_PULL  = 2'd1,
    PAD_OPEN_DRAIN = 2'd2,
    PAD_LOOPBACK   = 2'd3
  } pad_mode_e;

  // Command carried by a configuration write.
  typedef enum logic [1:0] {
    CFG_NOP          = 2'd0,
    CFG_SET_MODE     = 2'd1,
    CFG_CLEAR_FAULTS = 2'd2
  } cfg_op_e;

endpackage

// File: verilog/pad_config.sv
// ================================================
// Pad configuration block.
// Holds the mode of every pad and turns configuration
// writes into mode updates and a fault clear pulse.
// ================================================

`timescale 1ns/1ps

`include "pad_defs.svh"

module pad_config (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  cfg_we_i,
  input  pad_pkg::cfg_op_e      cfg_op_i,
  input  logic [`PAD_IDX_W-1:0] cfg_idx_i,
  input  pad_pkg::pad_mode_e    cfg_mode_i,
  output pad_pkg::pad_mode_e    mode_o [`PAD_NUM],
  output logic                  clear_o
);
  import pad_pkg::*;

  // One mode register per pad.
  pad_mode_e mode_q [`PAD_NUM];
  // Registered clear pulse towards the recorder.
  logic      clear_q;

  // Decoded write commands.
  logic      set_mode;
  logic      clear_req;

  // Opcode decode, only qualified by the write strobe.
  always_comb begin
    set_mode  = 1'b0;
    clear_req = 1'b0;
    unique case (cfg_op_i)
      CFG_NOP:          ;
      CFG_SET_MODE:     set_mode  = cfg_we_i;
      CFG_CLEAR_FAULTS: clear_req = cfg_we_i;
      default:          ;
    endcase
  end

  // Mode registers; the new mode applies from the next cycle.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `PAD_NUM; i++) begin
        mode_q[i] <= PAD_OFF;
      end
    end else begin
      for (int i = 0; i < `PAD_NUM; i++) begin
        // An index beyond the ring matches no pad.
        if (set_mode && (int'(cfg_idx_i) == i)) begin
          mode_q[i] <= cfg_mode_i;
        end
      end
    end
  end

  // The clear pulse lasts one cycle per strobed command.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      clear_q <= 1'b0;
    end else begin
      clear_q <= clear_req;
    end
  end

  assign mode_o  = mode_q;
  assign clear_o = clear_q;

  // A strobed mode write must address an existing pad.
  a_idx_in_range : assert property (@(posedge clk_i) disable iff (!rst_ni)
    set_mode |-> (int'(cfg_idx_i) < `PAD_NUM));

endmodule

// File: verilog/pad_cell.sv
// ================================================
// Pad cell.
// Resolves the wired-AND line for its mode, feeds the
// core input, retimes loopback and flags contention.
// ================================================

`timescale 1ns/1ps

module pad_cell (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  pad_pkg::pad_mode_e mode_i,
  input  logic               core_out_i,
  input  logic               core_oe_i,
  input  logic               ext_i,
  output logic               pad_o,
  output logic               core_in_o,
  output logic               fault_o
);
  import pad_pkg::*;

  // Value the pad itself puts on the line, 1 means released.
  logic pad_drive;
  // Loopback retiming stage.
  logic loop_q;
  // Drive contention in the current cycle.
  logic contention;
  // Registered contention pulse.
  logic fault_q;

  // Drive per mode.
  always_comb begin
    pad_drive = 1'b1;
    unique case (mode_i)
      PAD_OFF:        pad_drive = 1'b1;
      PAD_PUSH_PULL:  pad_drive = core_oe_i ? core_out_i : 1'b1;
      // Open drain only ever pulls low.
      PAD_OPEN_DRAIN: pad_drive = ~(core_oe_i & ~core_out_i);
      // Loopback releases the line.
      PAD_LOOPBACK:   pad_drive = 1'b1;
      default:        pad_drive = 1'b1;
    endcase
  end

  // The line is the wired-AND of both drivers.
  assign pad_o = pad_drive & ext_i;

  // Pad high against a device pulling low.
  assign contention = (mode_i == PAD_PUSH_PULL) & core_oe_i & core_out_i & ~ext_i;

  // Loopback register samples the core output every cycle,
  // so the first loopback cycle already sees the previous value.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      loop_q <= 1'b1;
    end else begin
      loop_q <= core_out_i;
    end
  end

  // Contention pulse, one cycle behind the condition.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fault_q <= 1'b0;
    end else begin
      fault_q <= contention;
    end
  end

  // Core sees the line, or its own output in loopback.
  assign core_in_o = (mode_i == PAD_LOOPBACK) ? loop_q : pad_o;
  assign fault_o   = fault_q;

  // In loopback the line is left to the device.
  a_loopback : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mode_i == PAD_LOOPBACK) |-> (pad_o == ext_i));

  // Open drain cannot fight the line, so no fault follows it.
  a_no_od_fault : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mode_i == PAD_OPEN_DRAIN) |=> !fault_o);

endmodule

// File: verilog/fault_recorder.sv
// ================================================
// Fault recorder.
// Sticky per-pad contention flags with a pulse on
// every newly recorded fault and a clear command.
// ================================================

`timescale 1ns/1ps

`include "pad_defs.svh"

module fault_recorder (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [`PAD_NUM-1:0] fault_i,
  input  logic                clear_i,
  output logic [`PAD_NUM-1:0] fault_sticky_o,
  output logic                fault_new_o
);

  // Sticky fault flags.
  logic [`PAD_NUM-1:0] sticky_q;
  // Faults on pads not yet recorded.
  logic [`PAD_NUM-1:0] fresh;
  // One-cycle new-fault pulse.
  logic                new_q;

  assign fresh = fault_i & ~sticky_q;

  // Clear wins over any fault arriving in the same cycle.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sticky_q <= '0;
      new_q    <= 1'b0;
    end else if (clear_i) begin
      sticky_q <= '0;
      new_q    <= 1'b0;
    end else begin
      sticky_q <= sticky_q | fault_i;
      // Repeats on an already flagged pad stay quiet.
      new_q    <= |fresh;
    end
  end

  assign fault_sticky_o = sticky_q;
  assign fault_new_o    = new_q;

  // A sticky bit only drops after a clear.
  a_sticky_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|($past(sticky_q) & ~sticky_q)) |-> $past(clear_i));

endmodule

// File: verilog/pad_ring_top.sv
// ================================================
// Pad ring top level.
// Configuration block, one pad cell per pad and the
// shared fault recorder.
// ================================================

`timescale 1ns/1ps

`include "pad_defs.svh"

module pad_ring_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Configuration writes.
  input  logic                  cfg_we_i,
  input  pad_pkg::cfg_op_e      cfg_op_i,
  input  logic [`PAD_IDX_W-1:0] cfg_idx_i,
  input  pad_pkg::pad_mode_e    cfg_mode_i,
  // Core side, one bit per pad.
  input  logic [`PAD_NUM-1:0]   core_out_i,
  input  logic [`PAD_NUM-1:0]   core_oe_i,
  // External devices, 1 means released.
  input  logic [`PAD_NUM-1:0]   ext_i,
  output logic [`PAD_NUM-1:0]   core_in_o,
  output logic [`PAD_NUM-1:0]   pad_o,
  // Fault reporting.
  output logic [`PAD_NUM-1:0]   fault_sticky_o,
  output logic                  fault_new_o
);
  import pad_pkg::*;

  // Mode of each pad from the configuration block.
  pad_mode_e           pad_mode [`PAD_NUM];
  // Clear pulse to the recorder.
  logic                fault_clear;
  // Contention pulses from the pad cells.
  logic [`PAD_NUM-1:0] pad_fault;

  pad_config u_pad_config (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cfg_we_i   (cfg_we_i),
    .cfg_op_i   (cfg_op_i),
    .cfg_idx_i  (cfg_idx_i),
    .cfg_mode_i (cfg_mode_i),
    .mode_o     (pad_mode),
    .clear_o    (fault_clear)
  );

  // One identical cell per pad.
  for (genvar p = 0; p < `PAD_NUM; p++) begin : g_pad
    pad_cell u_pad_cell (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .mode_i     (pad_mode[p]),
      .core_out_i (core_out_i[p]),
      .core_oe_i  (core_oe_i[p]),
      .ext_i      (ext_i[p]),
      .pad_o      (pad_o[p]),
      .core_in_o  (core_in_o[p]),
      .fault_o    (pad_fault[p])
    );
  end

  fault_recorder u_fault_recorder (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fault_i        (pad_fault),
    .clear_i        (fault_clear),
    .fault_sticky_o (fault_sticky_o),
    .fault_new_o    (fault_new_o)
  );

endmodule

// File: tb/tb_pad_ring.sv
// ==================================================
// Pad ring testbench.
// Drives random core and device traffic and checks
// the DUT against a reference model with assertions.
// ==================================================

`timescale 1ns/1ps

`include "pad_defs.svh"

module tb_pad_ring;
  import pad_pkg::*;

  localparam int IDX_W = `PAD_IDX_W;
  // Pad used for the contention tests.
  localparam int HOT_PAD = 2;

  logic                clk;
  logic                rst_n;
  logic                cfg_we;
  cfg_op_e             cfg_op;
  logic [IDX_W-1:0]    cfg_idx;
  pad_mode_e           cfg_mode;
  logic [`PAD_NUM-1:0] core_out;
  logic [`PAD_NUM-1:0] core_oe;
  logic [`PAD_NUM-1:0] ext;
  logic [`PAD_NUM-1:0] core_in;
  logic [`PAD_NUM-1:0] pad;
  logic [`PAD_NUM-1:0] sticky;
  logic                fault_new;

  // Reference model state, tracked from the writes this bench makes.
  pad_mode_e           model_mode [`PAD_NUM];
  logic [`PAD_NUM-1:0] prev_out;
  logic [`PAD_NUM-1:0] drive;
  logic [`PAD_NUM-1:0] cond;
  logic [`PAD_NUM-1:0] cond_q;
  logic [`PAD_NUM-1:0] exp_pad;
  logic [`PAD_NUM-1:0] exp_core_in;
  logic [`PAD_NUM-1:0] exp_sticky;
  logic                clr_q;
  logic                exp_new;

  int          errors;
  int          tests_run;
  int          err_base;
  logic [31:0] rng;

  // 32-bit xorshift step.
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  pad_ring_top dut_i (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .cfg_we_i       (cfg_we),
    .cfg_op_i       (cfg_op),
    .cfg_idx_i      (cfg_idx),
    .cfg_mode_i     (cfg_mode),
    .core_out_i     (core_out),
    .core_oe_i      (core_oe),
    .ext_i          (ext),
    .core_in_o      (core_in),
    .pad_o          (pad),
    .fault_sticky_o (sticky),
    .fault_new_o    (fault_new)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Expected line, core input and contention per pad.
  always_comb begin
    for (int p = 0; p < `PAD_NUM; p++) begin
      case (model_mode[p])
        PAD_PUSH_PULL:  drive[p] = core_oe[p] ? core_out[p] : 1'b1;
        PAD_OPEN_DRAIN: drive[p] = !(core_oe[p] && !core_out[p]);
        default:        drive[p] = 1'b1;
      endcase
      exp_pad[p]     = drive[p] & ext[p];
      exp_core_in[p] = (model_mode[p] == PAD_LOOPBACK) ? prev_out[p] : exp_pad[p];
      cond[p]        = (model_mode[p] == PAD_PUSH_PULL) & core_oe[p] & core_out[p] & ~ext[p];
    end
  end

  // Mode tracking, loopback delay and the two-edge fault path.
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int p = 0; p < `PAD_NUM; p++) begin
        model_mode[p] <= PAD_OFF;
      end
      prev_out   <= '1;
      cond_q     <= '0;
      clr_q      <= 1'b0;
      exp_sticky <= '0;
      exp_new    <= 1'b0;
    end else begin
      if (cfg_we && (cfg_op == CFG_SET_MODE) && (int'(cfg_idx) < `PAD_NUM)) begin
        model_mode[cfg_idx] <= cfg_mode;
      end
      clr_q    <= cfg_we && (cfg_op == CFG_CLEAR_FAULTS);
      prev_out <= core_out;
      cond_q   <= cond;
      // Clear wins over a fault in the same cycle.
      if (clr_q) begin
        exp_sticky <= '0;
        exp_new    <= 1'b0;
      end else begin
        exp_sticky <= exp_sticky | cond_q;
        exp_new    <= |(cond_q & ~exp_sticky);
      end
    end
  end

  a_pad_value : assert property (@(posedge clk) disable iff (!rst_n) pad == exp_pad)
    else begin
      $display("FAIL pad_o: got %h, expected %h", $sampled(pad), $sampled(exp_pad));
      errors++;
    end

  a_core_in_value : assert property (@(posedge clk) disable iff (!rst_n)
    core_in == exp_core_in)
    else begin
      $display("FAIL core_in_o: got %h, expected %h", $sampled(core_in),
               $sampled(exp_core_in));
      errors++;
    end

  a_sticky_value : assert property (@(posedge clk) disable iff (!rst_n)
    sticky == exp_sticky)
    else begin
      $display("FAIL fault_sticky_o: got %h, expected %h", $sampled(sticky),
               $sampled(exp_sticky));
      errors++;
    end

  a_new_value : assert property (@(posedge clk) disable iff (!rst_n) fault_new == exp_new)
    else begin
      $display("FAIL fault_new_o: got %h, expected %h", $sampled(fault_new),
               $sampled(exp_new));
      errors++;
    end

  // Random core and device drives, devices optionally held released.
  task automatic drive_random(input int cycles, input logic ext_random);
    repeat (cycles) begin
      @(negedge clk);
      rng      = xorshift(rng);
      core_out = rng[`PAD_NUM-1:0];
      rng      = xorshift(rng);
      core_oe  = rng[`PAD_NUM-1:0];
      rng      = xorshift(rng);
      ext      = ext_random ? rng[`PAD_NUM-1:0] : '1;
    end
  endtask

  task automatic drive_quiet();
    @(negedge clk);
    core_out = '0;
    core_oe  = '0;
    ext      = '1;
  endtask

  // Pad drives high while its device pulls low.
  task automatic drive_contention(input int pad_idx);
    @(negedge clk);
    core_out          = '0;
    core_oe           = '0;
    ext               = '1;
    core_out[pad_idx] = 1'b1;
    core_oe[pad_idx]  = 1'b1;
    ext[pad_idx]      = 1'b0;
  endtask

  task automatic cfg_write(input cfg_op_e op, input int idx, input pad_mode_e mode);
    @(negedge clk);
    cfg_we   = 1'b1;
    cfg_op   = op;
    cfg_idx  = IDX_W'(idx);
    cfg_mode = mode;
    @(negedge clk);
    cfg_we = 1'b0;
    cfg_op = CFG_NOP;
  endtask

  task automatic wait_sticky_clear();
    int cycles = 0;
    while ((sticky != '0) && (cycles < 8)) begin
      @(negedge clk);
      cycles++;
    end
    if (sticky != '0) begin
      $display("Timeout: sticky fault bits did not clear after the clear command");
      errors++;
    end
  endtask

  task automatic wait_new_fault();
    int cycles = 0;
    while (!fault_new && (cycles < 8)) begin
      @(negedge clk);
      cycles++;
    end
    if (!fault_new) begin
      $display("Timeout: no new-fault pulse after a contention");
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == err_base) begin
      $display("test %0d, %s: ok", tests_run, name);
    end else begin
      $display("test %0d, %s: %0d error(s)", tests_run, name, errors - err_base);
    end
    err_base = errors;
  endtask

  initial begin
    rng       = 32'd36591;
    errors    = 0;
    tests_run = 0;
    err_base  = 0;
    rst_n     = 1'b0;
    cfg_we    = 1'b0;
    cfg_op    = CFG_NOP;
    cfg_idx   = '0;
    cfg_mode  = PAD_OFF;
    core_out  = '0;
    core_oe   = '0;
    ext       = '1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    drive_random(20, 1'b0);
    report_test("reset state with pads off");

    // Each pad gets a random choice of the two driving modes.
    for (int p = 0; p < `PAD_NUM; p++) begin
      rng = xorshift(rng);
      cfg_write(CFG_SET_MODE, p, rng[0] ? PAD_PUSH_PULL : PAD_OPEN_DRAIN);
    end
    drive_random(200, 1'b1);
    report_test("push-pull and open-drain line");

    for (int p = 0; p < `PAD_NUM; p++) begin
      cfg_write(CFG_SET_MODE, p, PAD_LOOPBACK);
    end
    drive_random(100, 1'b1);
    report_test("loopback retiming");

    drive_quiet();
    cfg_write(CFG_CLEAR_FAULTS, 0, PAD_OFF);
    wait_sticky_clear();
    // Open drain first, while the pad is not yet flagged.
    cfg_write(CFG_SET_MODE, HOT_PAD, PAD_OPEN_DRAIN);
    drive_contention(HOT_PAD);
    repeat (4) drive_quiet();
    cfg_write(CFG_SET_MODE, HOT_PAD, PAD_PUSH_PULL);
    drive_contention(HOT_PAD);
    drive_quiet();
    wait_new_fault();
    // Repeat on an already flagged pad.
    drive_contention(HOT_PAD);
    repeat (4) drive_quiet();
    report_test("contention recording");

    cfg_write(CFG_CLEAR_FAULTS, 0, PAD_OFF);
    wait_sticky_clear();
    cfg_write(CFG_SET_MODE, HOT_PAD, PAD_PUSH_PULL);
    drive_contention(HOT_PAD);
    drive_quiet();
    wait_new_fault();
    repeat (3) drive_quiet();
    report_test("fault clear and re-arm");

    $display("%0d tests run, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+verilog
verilog/pad_pkg.sv
verilog/pad_config.sv
verilog/pad_cell.sv
verilog/fault_recorder.sv
verilog/pad_ring_top.sv
tb/tb_pad_ring.sv

// File: run_verilator.sh
#!/bin/sh
# Builds the pad ring testbench with Verilator and runs it.
# The run passes only if the testbench reports success.
cd "$(dirname "$0")" || exit 1

SIM_OUT=$(verilator --binary --timing --assert -f vlog.f \
  --top-module tb_pad_ring -o tb_pad_ring 2>&1 \
  && ./obj_dir/tb_pad_ring 2>&1) \
  || { echo "$SIM_OUT"; echo "Build or simulation failed"; exit 1; }

echo "$SIM_OUT"
echo "$SIM_OUT" | grep -q "All tests passed!" && exit 0 || exit 1
